// ==== source/vrf_pkg.sv ====
// Lane constants, element-width enum, VRF address union, command and payload structs
`default_nettype none

package vrf_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrBanks      = 4;
  localparam int unsigned BankIdxWidth = 2;
  localparam int unsigned NrVInsn      = 8;
  localparam int unsigned VidWidth     = 3;
  localparam int unsigned ElenWidth    = 64;
  localparam int unsigned StrbWidth    = 8;
  localparam int unsigned VAddrWidth   = 9;
  localparam int unsigned RowWidth     = VAddrWidth - BankIdxWidth;
  localparam int unsigned VRegWords    = 16;
  localparam int unsigned VlWidth      = 8;

  localparam int unsigned NrReadQueues = 3;
  localparam int unsigned NrWritePorts = 2;
  localparam int unsigned NrMasters    = 5;

  // Master indices seen by every bank arbiter
  localparam int unsigned QueueAluA  = 0;
  localparam int unsigned QueueAluB  = 1;
  localparam int unsigned QueueStore = 2;
  localparam int unsigned WrAlu      = 3;
  localparam int unsigned WrLoad     = 4;

  // Write ports counted from the first write master
  localparam int unsigned PortAlu = WrAlu - NrReadQueues;
  localparam int unsigned PortLdu = WrLoad - NrReadQueues;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef struct packed {
    logic [RowWidth-1:0]     row;
    logic [BankIdxWidth-1:0] bank;
  } vrf_row_bank_t;

  // Word address, used flat for stepping and split for bank selection
  typedef union packed {
    logic [VAddrWidth-1:0] word;
    vrf_row_bank_t         rb;
  } vrf_addr_u;

  typedef struct packed {
    logic [VidWidth-1:0] id;
    logic [4:0]          vs;
    logic [VlWidth-1:0]  vl;
    vew_e                eew;
    logic [NrVInsn-1:0]  hazard;
  } operand_request_t;

  typedef struct packed {
    vew_e               eew;
    logic [VlWidth-1:0] elem_count;
  } queue_cmd_t;

  typedef struct packed {
    logic [RowWidth-1:0]  row;
    logic                 wen;
    logic [ElenWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
    logic [1:0]           tgt_queue;
  } vrf_payload_t;

  typedef struct packed {
    logic [VidWidth-1:0]  id;
    vrf_addr_u            addr;
    logic [ElenWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== source/rr_arbiter.sv ====
// Round-robin arbiter with stored pointer and VRF payload multiplexer
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumIn = 2
) (
  input  wire                                    clk_i,
  input  wire                                    rst_ni,
  input  wire  [NumIn-1:0]                       req_i,
  input  wire  vrf_pkg::vrf_payload_t [NumIn-1:0] data_i,
  input  wire                                    gnt_en_i,
  output logic [NumIn-1:0]                       gnt_o,
  output logic                                   req_o,
  output vrf_pkg::vrf_payload_t                  data_o
);

  // One-hot position of the last consumed grant, zero after reset
  logic [NumIn-1:0] last_q;
  logic [NumIn-1:0] after_last;
  logic [NumIn-1:0] sel;

  // Requesters above the last winner are searched first
  assign after_last = ~((last_q << 1) - 1'b1);

  always_comb begin : p_select
    logic found;
    found  = 1'b0;
    sel    = '0;
    data_o = '0;
    for (int i = 0; i < NumIn; i++) begin
      if (!found && req_i[i] && after_last[i]) begin
        sel[i] = 1'b1;
        found  = 1'b1;
      end
    end
    // Wrap around to the lowest index
    for (int i = 0; i < NumIn; i++) begin
      if (!found && req_i[i]) begin
        sel[i] = 1'b1;
        found  = 1'b1;
      end
    end
    for (int i = 0; i < NumIn; i++) begin
      if (sel[i]) begin
        data_o = data_i[i];
      end
    end
  end

  assign req_o = |req_i;
  assign gnt_o = sel & {NumIn{gnt_en_i}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= '0;
    end else if (req_o && gnt_en_i) begin
      last_q <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== source/bank_arbiter.sv ====
// Two-level priority arbitration for one VRF bank and its port drive
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
  input  wire                                            clk_i,
  input  wire                                            rst_ni,
  input  wire  [vrf_pkg::NrMasters-1:0]                  req_i,
  input  wire  vrf_pkg::vrf_payload_t [vrf_pkg::NrMasters-1:0] payload_i,
  output logic [vrf_pkg::NrMasters-1:0]                  gnt_o,
  output logic                                           vrf_req_o,
  output vrf_pkg::vrf_payload_t                          vrf_payload_o
);

  logic [2:0]            hp_gnt;
  logic                  hp_req;
  vrf_pkg::vrf_payload_t hp_payload;
  logic [1:0]            lp_gnt;
  logic                  lp_req;
  vrf_pkg::vrf_payload_t lp_payload;

  // ALU operands and ALU results
  rr_arbiter #(
    .NumIn(3)
  ) i_hp_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   ({req_i[vrf_pkg::WrAlu], req_i[vrf_pkg::QueueAluB], req_i[vrf_pkg::QueueAluA]}),
    .data_i  ({payload_i[vrf_pkg::WrAlu], payload_i[vrf_pkg::QueueAluB],
               payload_i[vrf_pkg::QueueAluA]}),
    .gnt_en_i(1'b1),
    .gnt_o   (hp_gnt),
    .req_o   (hp_req),
    .data_o  (hp_payload)
  );

  // Store operands and load results, served only when the high group is idle
  rr_arbiter #(
    .NumIn(2)
  ) i_lp_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   ({req_i[vrf_pkg::WrLoad], req_i[vrf_pkg::QueueStore]}),
    .data_i  ({payload_i[vrf_pkg::WrLoad], payload_i[vrf_pkg::QueueStore]}),
    .gnt_en_i(!hp_req),
    .gnt_o   (lp_gnt),
    .req_o   (lp_req),
    .data_o  (lp_payload)
  );

  assign gnt_o[vrf_pkg::QueueAluA]  = hp_gnt[0];
  assign gnt_o[vrf_pkg::QueueAluB]  = hp_gnt[1];
  assign gnt_o[vrf_pkg::WrAlu]      = hp_gnt[2];
  assign gnt_o[vrf_pkg::QueueStore] = lp_gnt[0];
  assign gnt_o[vrf_pkg::WrLoad]     = lp_gnt[1];

  // The VRF takes every request, so the winner goes straight out
  assign vrf_req_o     = hp_req || lp_req;
  assign vrf_payload_o = hp_req ? hp_payload : lp_payload;

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
// Write-back ports, load stream register, final grant and written-instruction vector
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  wire                                                     clk_i,
  input  wire                                                     rst_ni,
  input  wire                                                     alu_wb_req_i,
  input  wire  vrf_pkg::wb_req_t                                  alu_wb_i,
  output logic                                                    alu_wb_gnt_o,
  input  wire                                                     ldu_wb_req_i,
  input  wire  vrf_pkg::wb_req_t                                  ldu_wb_i,
  output logic                                                    ldu_wb_gnt_o,
  output logic                                                    ldu_wb_final_gnt_o,
  output logic [vrf_pkg::NrWritePorts-1:0][vrf_pkg::NrBanks-1:0]  wr_req_o,
  input  wire  [vrf_pkg::NrWritePorts-1:0][vrf_pkg::NrBanks-1:0]  wr_gnt_i,
  output vrf_pkg::vrf_payload_t [vrf_pkg::NrWritePorts-1:0]       wr_payload_o,
  output logic [vrf_pkg::NrVInsn-1:0]                             written_q_o,
  output logic [vrf_pkg::NrVInsn-1:0]                             written_d_o
);

  logic             ldu_valid_q;
  vrf_pkg::wb_req_t ldu_q;
  logic             ldu_gnt;

  function automatic vrf_pkg::vrf_payload_t wb_payload(vrf_pkg::wb_req_t req);
    vrf_pkg::vrf_payload_t p;
    p.row       = req.addr.rb.row;
    p.wen       = 1'b1;
    p.wdata     = req.wdata;
    p.be        = req.be;
    p.tgt_queue = '0;
    return p;
  endfunction

  assign alu_wb_gnt_o = |wr_gnt_i[vrf_pkg::PortAlu];
  assign ldu_gnt      = |wr_gnt_i[vrf_pkg::PortLdu];

  ////////////////////////////////////////////////////////////////////////////
  // Load stream register
  ////////////////////////////////////////////////////////////////////////////

  // Ready when empty or when the held word leaves this cycle
  assign ldu_wb_gnt_o = !ldu_valid_q || ldu_gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q        <= 1'b0;
      ldu_wb_final_gnt_o <= 1'b0;
    end else begin
      if (ldu_wb_gnt_o) begin
        ldu_valid_q <= ldu_wb_req_i;
      end
      // Tells the load unit the word really reached the bank
      ldu_wb_final_gnt_o <= ldu_gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_wb_req_i && ldu_wb_gnt_o) begin
      ldu_q <= ldu_wb_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      wr_req_o[vrf_pkg::PortAlu][b] = alu_wb_req_i && (alu_wb_i.addr.rb.bank == b);
      wr_req_o[vrf_pkg::PortLdu][b] = ldu_valid_q && (ldu_q.addr.rb.bank == b);
    end
  end

  assign wr_payload_o[vrf_pkg::PortAlu] = wb_payload(alu_wb_i);
  assign wr_payload_o[vrf_pkg::PortLdu] = wb_payload(ldu_q);

  // Instructions that wrote a word this cycle
  always_comb begin
    for (int k = 0; k < vrf_pkg::NrVInsn; k++) begin
      written_d_o[k] = (alu_wb_gnt_o && (alu_wb_i.id == k)) ||
                       (ldu_gnt && (ldu_q.id == k));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q_o <= '0;
    end else begin
      written_q_o <= written_d_o;
    end
  end

endmodule

`default_nettype wire

// ==== source/requester_sequencer.sv ====
// Per-queue operand request FSMs, hazard stall and VRF bank request generation
`timescale 1ns/1ps
`default_nettype none

module requester_sequencer (
  input  wire                                                     clk_i,
  input  wire                                                     rst_ni,
  input  wire  [vrf_pkg::NrVInsn-1:0][vrf_pkg::NrVInsn-1:0]       hazard_table_i,
  input  wire  vrf_pkg::operand_request_t [vrf_pkg::NrReadQueues-1:0] op_req_i,
  input  wire  [vrf_pkg::NrReadQueues-1:0]                        op_req_valid_i,
  output logic [vrf_pkg::NrReadQueues-1:0]                        op_req_ready_o,
  input  wire  [vrf_pkg::NrReadQueues-1:0]                        queue_ready_i,
  output logic [vrf_pkg::NrReadQueues-1:0]                        operand_issued_o,
  output vrf_pkg::queue_cmd_t [vrf_pkg::NrReadQueues-1:0]         queue_cmd_o,
  output logic [vrf_pkg::NrReadQueues-1:0]                        queue_cmd_valid_o,
  input  wire  [vrf_pkg::NrVInsn-1:0]                             written_q_i,
  input  wire  [vrf_pkg::NrVInsn-1:0]                             written_d_i,
  output logic [vrf_pkg::NrReadQueues-1:0][vrf_pkg::NrBanks-1:0]  rd_req_o,
  input  wire  [vrf_pkg::NrReadQueues-1:0][vrf_pkg::NrBanks-1:0]  rd_gnt_i,
  output vrf_pkg::vrf_payload_t [vrf_pkg::NrReadQueues-1:0]       rd_payload_o
);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  // What a queue needs to walk one vector operand
  typedef struct packed {
    logic [vrf_pkg::VidWidth-1:0] id;
    vrf_pkg::vrf_addr_u           addr;
    logic [vrf_pkg::VlWidth-1:0]  len;
    vrf_pkg::vew_e                eew;
    logic [vrf_pkg::NrVInsn-1:0]  hazard;
  } meta_t;

  for (genvar q = 0; q < vrf_pkg::NrReadQueues; q++) begin : gen_queue
    state_e                      state_d;
    state_e                      state_q;
    meta_t                       meta_d;
    meta_t                       meta_q;
    logic                        stall;
    logic                        issued;
    logic                        accept;
    logic [vrf_pkg::VlWidth-1:0] elems_per_word;

    // Read no faster than the producers we depend on write
    assign stall          = |(meta_q.hazard & ~written_q_i);
    assign issued         = |rd_gnt_i[q];
    assign elems_per_word = vrf_pkg::VlWidth'(8) >> meta_q.eew;

    assign operand_issued_o[q] = issued;
    assign queue_cmd_o[q]      = '{eew: op_req_i[q].eew, elem_count: op_req_i[q].vl};
    assign rd_payload_o[q]     = '{row: meta_q.addr.rb.row, wen: 1'b0, wdata: '0,
                                   be: '0, tgt_queue: 2'(q)};

    always_comb begin
      state_d              = state_q;
      meta_d               = meta_q;
      accept               = 1'b0;
      op_req_ready_o[q]    = 1'b0;
      queue_cmd_valid_o[q] = 1'b0;
      rd_req_o[q]          = '0;

      case (state_q)
        IDLE: accept = 1'b1;
        REQUESTING: begin
          if (queue_ready_i[q]) begin
            rd_req_o[q][meta_q.addr.rb.bank] = !stall;
            if (issued) begin
              meta_d.addr.word = meta_q.addr.word + 1'b1;
              if (meta_q.len > elems_per_word) begin
                meta_d.len = meta_q.len - elems_per_word;
              end else begin
                meta_d.len = '0;
              end
            end
            // Last word out, a new command may follow at once
            if (meta_d.len == '0) begin
              state_d = IDLE;
              accept  = 1'b1;
            end
          end
        end
      endcase

      if (accept && op_req_valid_i[q]) begin
        op_req_ready_o[q] = 1'b1;
        meta_d.id         = op_req_i[q].id;
        meta_d.addr.word  = vrf_pkg::VAddrWidth'(op_req_i[q].vs * vrf_pkg::VRegWords);
        meta_d.len        = op_req_i[q].vl;
        meta_d.eew        = op_req_i[q].eew;
        meta_d.hazard     = op_req_i[q].hazard;
        // Zero-length commands are acknowledged and muted
        if (op_req_i[q].vl != '0) begin
          state_d              = REQUESTING;
          queue_cmd_valid_o[q] = 1'b1;
        end
      end

      // Drop retired producers, but keep a bit until its last write has paced a read
      meta_d.hazard = meta_d.hazard & (hazard_table_i[meta_d.id] | written_d_i);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q <= IDLE;
        meta_q  <= '0;
      end else begin
        state_q <= state_d;
        meta_q  <= meta_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/operand_requester.sv ====
// Lane operand requester top level with sequencer, write-back stage and bank arbiters
`timescale 1ns/1ps
`default_nettype none

module operand_requester (
  input  wire                                                clk_i,
  input  wire                                                rst_ni,
  input  wire  [vrf_pkg::NrVInsn-1:0][vrf_pkg::NrVInsn-1:0]  hazard_table_i,
  // Operand queues
  input  wire  vrf_pkg::operand_request_t [vrf_pkg::NrReadQueues-1:0] op_req_i,
  input  wire  [vrf_pkg::NrReadQueues-1:0]                   op_req_valid_i,
  output logic [vrf_pkg::NrReadQueues-1:0]                   op_req_ready_o,
  input  wire  [vrf_pkg::NrReadQueues-1:0]                   queue_ready_i,
  output logic [vrf_pkg::NrReadQueues-1:0]                   operand_issued_o,
  output vrf_pkg::queue_cmd_t [vrf_pkg::NrReadQueues-1:0]    queue_cmd_o,
  output logic [vrf_pkg::NrReadQueues-1:0]                   queue_cmd_valid_o,
  // Result write-backs
  input  wire                                                alu_wb_req_i,
  input  wire  vrf_pkg::wb_req_t                             alu_wb_i,
  output logic                                               alu_wb_gnt_o,
  input  wire                                                ldu_wb_req_i,
  input  wire  vrf_pkg::wb_req_t                             ldu_wb_i,
  output logic                                               ldu_wb_gnt_o,
  output logic                                               ldu_wb_final_gnt_o,
  // VRF banks
  output logic [vrf_pkg::NrBanks-1:0]                        vrf_req_o,
  output vrf_pkg::vrf_payload_t [vrf_pkg::NrBanks-1:0]       vrf_payload_o
);

  logic [vrf_pkg::NrReadQueues-1:0][vrf_pkg::NrBanks-1:0] rd_req;
  logic [vrf_pkg::NrReadQueues-1:0][vrf_pkg::NrBanks-1:0] rd_gnt;
  vrf_pkg::vrf_payload_t [vrf_pkg::NrReadQueues-1:0]      rd_payload;
  logic [vrf_pkg::NrWritePorts-1:0][vrf_pkg::NrBanks-1:0] wr_req;
  logic [vrf_pkg::NrWritePorts-1:0][vrf_pkg::NrBanks-1:0] wr_gnt;
  vrf_pkg::vrf_payload_t [vrf_pkg::NrWritePorts-1:0]      wr_payload;
  logic [vrf_pkg::NrVInsn-1:0]                            written_q;
  logic [vrf_pkg::NrVInsn-1:0]                            written_d;
  logic [vrf_pkg::NrBanks-1:0][vrf_pkg::NrMasters-1:0]    bank_req;
  logic [vrf_pkg::NrBanks-1:0][vrf_pkg::NrMasters-1:0]    bank_gnt;
  vrf_pkg::vrf_payload_t [vrf_pkg::NrMasters-1:0]         master_payload;

  requester_sequencer i_requester_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .hazard_table_i   (hazard_table_i),
    .op_req_i         (op_req_i),
    .op_req_valid_i   (op_req_valid_i),
    .op_req_ready_o   (op_req_ready_o),
    .queue_ready_i    (queue_ready_i),
    .operand_issued_o (operand_issued_o),
    .queue_cmd_o      (queue_cmd_o),
    .queue_cmd_valid_o(queue_cmd_valid_o),
    .written_q_i      (written_q),
    .written_d_i      (written_d),
    .rd_req_o         (rd_req),
    .rd_gnt_i         (rd_gnt),
    .rd_payload_o     (rd_payload)
  );

  writeback_stage i_writeback_stage (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .alu_wb_req_i      (alu_wb_req_i),
    .alu_wb_i          (alu_wb_i),
    .alu_wb_gnt_o      (alu_wb_gnt_o),
    .ldu_wb_req_i      (ldu_wb_req_i),
    .ldu_wb_i          (ldu_wb_i),
    .ldu_wb_gnt_o      (ldu_wb_gnt_o),
    .ldu_wb_final_gnt_o(ldu_wb_final_gnt_o),
    .wr_req_o          (wr_req),
    .wr_gnt_i          (wr_gnt),
    .wr_payload_o      (wr_payload),
    .written_q_o       (written_q),
    .written_d_o       (written_d)
  );

  // Read queues hold the low master indices, write ports follow
  assign master_payload = {wr_payload, rd_payload};

  for (genvar b = 0; b < vrf_pkg::NrBanks; b++) begin : gen_bank
    // Swap from per-source bank vectors to per-bank master vectors
    for (genvar q = 0; q < vrf_pkg::NrReadQueues; q++) begin : gen_rd
      assign bank_req[b][q] = rd_req[q][b];
      assign rd_gnt[q][b]   = bank_gnt[b][q];
    end
    for (genvar w = 0; w < vrf_pkg::NrWritePorts; w++) begin : gen_wr
      assign bank_req[b][vrf_pkg::NrReadQueues+w] = wr_req[w][b];
      assign wr_gnt[w][b] = bank_gnt[b][vrf_pkg::NrReadQueues+w];
    end

    bank_arbiter i_bank_arbiter (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .payload_i    (master_payload),
      .gnt_o        (bank_gnt[b]),
      .vrf_req_o    (vrf_req_o[b]),
      .vrf_payload_o(vrf_payload_o[b])
    );
  end

endmodule

`default_nettype wire

// ==== tests/tb_operand_requester.sv ====
// Operand requester testbench with clock, reset, stimulus, reference model, monitor and scenarios
`timescale 1ns/1ps
`default_nettype none

module tb_operand_requester;

  localparam int TimeoutCycles = 300;

  // One VRF write as seen on a bank port
  typedef struct packed {
    logic [1:0]  bank;
    logic [6:0]  row;
    logic [63:0] wdata;
    logic [7:0]  be;
  } wr_entry_t;

  logic clk;
  logic rst_n;
  logic [vrf_pkg::NrVInsn-1:0][vrf_pkg::NrVInsn-1:0]         hazard_table;
  vrf_pkg::operand_request_t [vrf_pkg::NrReadQueues-1:0]     op_req;
  logic [vrf_pkg::NrReadQueues-1:0]                          op_req_valid;
  logic [vrf_pkg::NrReadQueues-1:0]                          op_req_ready;
  logic [vrf_pkg::NrReadQueues-1:0]                          queue_ready;
  logic [vrf_pkg::NrReadQueues-1:0]                          operand_issued;
  vrf_pkg::queue_cmd_t [vrf_pkg::NrReadQueues-1:0]           queue_cmd;
  logic [vrf_pkg::NrReadQueues-1:0]                          queue_cmd_valid;
  logic                                                      alu_wb_req;
  vrf_pkg::wb_req_t                                          alu_wb;
  logic                                                      alu_wb_gnt;
  logic                                                      ldu_wb_req;
  vrf_pkg::wb_req_t                                          ldu_wb;
  logic                                                      ldu_wb_gnt;
  logic                                                      ldu_final_gnt;
  logic [vrf_pkg::NrBanks-1:0]                               vrf_req;
  vrf_pkg::vrf_payload_t [vrf_pkg::NrBanks-1:0]              vrf_payload;

  integer    seed;
  int        rd_count  [vrf_pkg::NrReadQueues];
  int        exp_vs    [vrf_pkg::NrReadQueues];
  int        exp_words [vrf_pkg::NrReadQueues];
  int        final_cnt;
  wr_entry_t wr_log[$];
  wr_entry_t exp_wr[$];

  operand_requester i_operand_requester (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .hazard_table_i    (hazard_table),
    .op_req_i          (op_req),
    .op_req_valid_i    (op_req_valid),
    .op_req_ready_o    (op_req_ready),
    .queue_ready_i     (queue_ready),
    .operand_issued_o  (operand_issued),
    .queue_cmd_o       (queue_cmd),
    .queue_cmd_valid_o (queue_cmd_valid),
    .alu_wb_req_i      (alu_wb_req),
    .alu_wb_i          (alu_wb),
    .alu_wb_gnt_o      (alu_wb_gnt),
    .ldu_wb_req_i      (ldu_wb_req),
    .ldu_wb_i          (ldu_wb),
    .ldu_wb_gnt_o      (ldu_wb_gnt),
    .ldu_wb_final_gnt_o(ldu_final_gnt),
    .vrf_req_o         (vrf_req),
    .vrf_payload_o     (vrf_payload)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Each 64-bit word holds 8 >> eew elements
  function automatic int expected_words(input int vl, input int eew);
    int per_word;
    per_word = 8 >> eew;
    return (vl + per_word - 1) / per_word;
  endfunction

  // Register vs starts at vs * VRegWords and its words follow one by one
  function automatic int expected_addr(input int vs, input int idx);
    return (vs * vrf_pkg::VRegWords + idx) % (1 << vrf_pkg::VAddrWidth);
  endfunction

  // Low address bits pick the bank and the rest is the row
  function automatic wr_entry_t expected_write(input vrf_pkg::wb_req_t w);
    wr_entry_t e;
    e.bank  = 2'(w.addr.word % vrf_pkg::NrBanks);
    e.row   = 7'(w.addr.word / vrf_pkg::NrBanks);
    e.wdata = w.wdata;
    e.be    = w.be;
    return e;
  endfunction

  function automatic vrf_pkg::wb_req_t make_wb(input int id, input int word, input int be);
    vrf_pkg::wb_req_t w;
    w.id        = 3'(id);
    w.addr.word = 9'(word);
    w.wdata     = {$random(seed), $random(seed)};
    w.be        = 8'(be);
    return w;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("** Error at time %0t: %s, got %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // Every read is checked against the next reference address of its queue
  always @(posedge clk) begin : p_monitor
    vrf_pkg::vrf_payload_t p;
    wr_entry_t             e;
    int                    q;
    int                    word;
    if (rst_n) begin
      for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
        p = vrf_payload[b];
        if (vrf_req[b] && p.wen) begin
          e.bank  = 2'(b);
          e.row   = p.row;
          e.wdata = p.wdata;
          e.be    = p.be;
          wr_log.push_back(e);
        end else if (vrf_req[b]) begin
          q = int'(p.tgt_queue);
          check_value(q < vrf_pkg::NrReadQueues, 1, "read tagged with a known queue");
          check_value(rd_count[q] < exp_words[q], 1, "no read beyond the vector length");
          word = expected_addr(exp_vs[q], rd_count[q]);
          check_value(b, word % vrf_pkg::NrBanks, "read bank");
          check_value(p.row, word / vrf_pkg::NrBanks, "read row");
          rd_count[q]++;
        end
      end
      if (ldu_final_gnt) begin
        final_cnt++;
      end
    end
  end

  task automatic compare_writes();
    check_value(wr_log.size(), exp_wr.size(), "number of VRF writes");
    for (int i = 0; i < exp_wr.size(); i++) begin
      check_value(wr_log[i].bank, exp_wr[i].bank, "write bank");
      check_value(wr_log[i].row, exp_wr[i].row, "write row");
      check_value(wr_log[i].wdata, exp_wr[i].wdata, "write data");
      check_value(wr_log[i].be, exp_wr[i].be, "write byte enables");
    end
    wr_log.delete();
    exp_wr.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks are called and return on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_cmd(input int q, input int id, input int vs, input logic [7:0] vl,
                          input vrf_pkg::vew_e eew, input logic [7:0] hazard,
                          output int cycles);
    vrf_pkg::operand_request_t req;
    req.id         = 3'(id);
    req.vs         = 5'(vs);
    req.vl         = vl;
    req.eew        = eew;
    req.hazard     = hazard;
    exp_vs[q]      = vs;
    exp_words[q]   = expected_words(vl, int'(eew));
    rd_count[q]    = 0;
    op_req[q]       = req;
    op_req_valid[q] = 1'b1;
    @(posedge clk);
    cycles = 1;
    while (!op_req_ready[q] && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!op_req_ready[q]) begin
      stop_run($sformatf("Timeout: queue %0d never accepted its command", q));
    end
    check_value(queue_cmd_valid[q], vl != 0, "queue command valid");
    if (vl != 0) begin
      check_value(queue_cmd[q].elem_count, vl, "queue command element count");
      check_value(queue_cmd[q].eew, eew, "queue command element width");
    end
    @(negedge clk);
    op_req_valid[q] = 1'b0;
  endtask

  task automatic wait_reads(input int q, input int n);
    int cycles;
    cycles = 0;
    while (rd_count[q] < n && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (rd_count[q] < n) begin
      stop_run($sformatf("Timeout: queue %0d issued %0d of %0d reads", q, rd_count[q], n));
    end
  endtask

  task automatic alu_write(input vrf_pkg::wb_req_t w);
    int cycles;
    alu_wb     = w;
    alu_wb_req = 1'b1;
    @(posedge clk);
    cycles = 1;
    while (!alu_wb_gnt && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!alu_wb_gnt) begin
      stop_run("Timeout: the ALU write was never granted");
    end
    exp_wr.push_back(expected_write(w));
    @(negedge clk);
    alu_wb_req = 1'b0;
  endtask

  task automatic load_write(input vrf_pkg::wb_req_t w);
    int cycles;
    ldu_wb     = w;
    ldu_wb_req = 1'b1;
    @(posedge clk);
    cycles = 1;
    while (!ldu_wb_gnt && cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!ldu_wb_gnt) begin
      stop_run("Timeout: the load write was never granted");
    end
    exp_wr.push_back(expected_write(w));
    @(negedge clk);
    ldu_wb_req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int               cycles;
    int               win;
    int               prev;
    int               writes;
    logic [7:0]       vl;
    vrf_pkg::wb_req_t w;

    seed         = 32'hd2363e5f;
    final_cnt    = 0;
    rst_n        = 1'b0;
    hazard_table = '0;
    op_req       = '0;
    op_req_valid = '0;
    queue_ready  = '1;
    alu_wb_req   = 1'b0;
    alu_wb       = '0;
    ldu_wb_req   = 1'b0;
    ldu_wb       = '0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value(op_req_ready, 0, "ready low in reset");
    check_value(queue_cmd_valid, 0, "queue command valid low in reset");
    check_value(vrf_req, 0, "no VRF request in reset");
    check_value(alu_wb_gnt, 0, "ALU grant low in reset");
    check_value(ldu_wb_gnt, 1, "load grant high with an empty register");
    check_value(ldu_final_gnt, 0, "final grant low in reset");
    rst_n = 1'b1;

    // Plain read and then a second command right behind it
    vl = 8'(($random(seed) & 32'h3f) + 1);
    send_cmd(vrf_pkg::QueueAluA, 1, 3, vl, vrf_pkg::EW32, '0, cycles);
    wait_reads(vrf_pkg::QueueAluA, expected_words(vl, 2));
    repeat (2) @(negedge clk);
    vl = 8'($random(seed) | 1);
    send_cmd(vrf_pkg::QueueAluA, 2, 5, vl, vrf_pkg::EW8, '0, cycles);
    check_value(cycles, 1, "idle queue accepts a command at once");
    wait_reads(vrf_pkg::QueueAluA, expected_words(vl, 0));

    // Zero length is muted and back-pressure pauses a vector
    send_cmd(vrf_pkg::QueueAluB, 3, 7, 8'd0, vrf_pkg::EW64, '0, cycles);
    repeat (5) @(negedge clk);
    send_cmd(vrf_pkg::QueueAluB, 3, 4, 8'd32, vrf_pkg::EW16, '0, cycles);
    wait_reads(vrf_pkg::QueueAluB, 3);
    queue_ready[1] = 1'b0;
    repeat (4) @(negedge clk);
    check_value(rd_count[1], 3, "no read while the queue is full");
    queue_ready[1] = 1'b1;
    wait_reads(vrf_pkg::QueueAluB, 8);

    // ALU write holds bank 0 against the store queue for six cycles
    w          = make_wb(2, 9'h040, 8'hff);
    alu_wb     = w;
    alu_wb_req = 1'b1;
    send_cmd(vrf_pkg::QueueStore, 3, 0, 8'd1, vrf_pkg::EW64, '0, cycles);
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_value(rd_count[2], 0, "store read waits for the ALU write");
    alu_wb_req = 1'b0;
    repeat (6) exp_wr.push_back(expected_write(w));
    wait_reads(vrf_pkg::QueueStore, 1);
    compare_writes();

    // Two ALU readers meet on bank 0 again and again
    queue_ready[0] = 1'b0;
    queue_ready[1] = 1'b0;
    send_cmd(vrf_pkg::QueueAluA, 1, 8, 8'd16, vrf_pkg::EW64, '0, cycles);
    send_cmd(vrf_pkg::QueueAluB, 2, 10, 8'd16, vrf_pkg::EW64, '0, cycles);
    queue_ready[0] = 1'b1;
    queue_ready[1] = 1'b1;
    prev = -1;
    for (int r = 0; r < 4; r++) begin
      @(posedge clk);
      check_value(operand_issued[0] ^ operand_issued[1], 1, "one winner per bank conflict");
      win = operand_issued[1] ? 1 : 0;
      if (prev >= 0) begin
        check_value(win != prev, 1, "conflict winner alternates");
      end
      prev = win;
      @(negedge clk);
      queue_ready[1-win] = 1'b0;
      // Winner walks banks 1 to 3 alone and comes back to bank 0
      repeat (3) begin
        @(posedge clk);
        check_value(operand_issued[win], 1, "lone reader granted every cycle");
      end
      @(negedge clk);
      queue_ready[1-win] = 1'b1;
    end
    wait_reads(vrf_pkg::QueueAluA, 16);
    wait_reads(vrf_pkg::QueueAluB, 16);

    // Load writes back to back through the stream register
    load_write(make_wb(5, 9'h0b7, 8'h3c));
    load_write(make_wb(5, 9'h0b8, 8'hff));
    load_write(make_wb(6, 9'h121, 8'h01));
    cycles = 0;
    while ((final_cnt < 3 || wr_log.size() < 3) && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (final_cnt < 3 || wr_log.size() < 3) begin
      stop_run("Timeout: load writes or their final grants went missing");
    end
    repeat (3) @(negedge clk);
    check_value(final_cnt, 3, "one final grant per load write");
    compare_writes();

    // Instruction 4 waits on instruction 6 and reads are paced by its writes
    hazard_table[4] = 8'h40;
    send_cmd(vrf_pkg::QueueAluA, 4, 6, 8'd4, vrf_pkg::EW64, 8'h40, cycles);
    repeat (6) @(negedge clk);
    check_value(rd_count[0], 0, "hazard holds back the reads");
    writes = 0;
    while (rd_count[0] < 4 && writes < 8) begin
      alu_write(make_wb(6, 9'h006, 8'hff));
      writes++;
      repeat (3) @(negedge clk);
      check_value(rd_count[0] <= writes, 1, "at most one read per producer write");
    end
    check_value(rd_count[0], 4, "paced reads complete");
    compare_writes();
    hazard_table[4] = '0;
    send_cmd(vrf_pkg::QueueAluA, 4, 6, 8'd4, vrf_pkg::EW64, 8'h40, cycles);
    wait_reads(vrf_pkg::QueueAluA, 4);

    repeat (3) @(negedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/vrf_pkg.sv
source/rr_arbiter.sv
source/bank_arbiter.sv
source/writeback_stage.sv
source/requester_sequencer.sv
source/operand_requester.sv
tests/tb_operand_requester.sv
